// ==== zx_host_core_pkg.sv ====
// Shared bus, paging and speed types for the Spectrum host core, compiled before all modules
package zx_host_core_pkg;

	// ========================================
	// Sizes and memory map
	// ========================================

	// Default SDRAM address width
	localparam int RAM_AW = 25;

	// ROM area, placed at bits 20:16 of ROM addresses
	localparam logic [4:0] ROM_BASE = 5'h17;

	// Fixed banks behind 4000 and 8000
	localparam logic [5:0] BANK_SCREEN = 6'd5;
	localparam logic [5:0] BANK_MID = 6'd2;

	// Profi 1024K extended page port
	localparam logic [15:0] PORT_DFFD = 16'hDFFD;

	// ========================================
	// Turbo speeds
	// ========================================

	// Divider mask, the number of ones sets the period as 2^k clocks
	typedef logic [4:0] speed_t;

	localparam speed_t SPEED_3M5 = 5'b11111;
	localparam speed_t SPEED_7M = 5'b01111;
	localparam speed_t SPEED_14M = 5'b00111;
	localparam speed_t SPEED_28M = 5'b00011;
	localparam speed_t SPEED_56M = 5'b00001;

	// ========================================
	// Bus and port types
	// ========================================

	// Memory models, sampled while reset is high
	typedef enum logic [1:0] {
		MODE_128K = 2'd0,
		MODE_P512 = 2'd1,
		MODE_P1024 = 2'd2,
		MODE_48K = 2'd3
	} mem_mode_t;

	// CPU bus as seen by the core, all strobes active high
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0] dout;
		logic mreq;
		logic iorq;
		logic rd;
		logic wr;
		logic m1;
	} cpu_bus_t;

	// SDRAM request, held only as long as the CPU cycle lasts
	typedef struct packed {
		logic [RAM_AW-1:0] addr;
		logic [7:0] din;
		logic rd;
		logic we;
	} ram_req_t;

	// ULA output latch of port FE
	typedef struct packed {
		logic [2:0] border;
		logic ear;
		logic mic;
	} ula_port_t;

	// Paging state from 7FFD and the extended ports
	typedef struct packed {
		logic [1:0] rom_page;
		logic [5:0] ram_page;
		logic scr_page;
	} page_state_t;

endpackage

// ==== cpu_clock_gen.sv ====
// CPU clock-enable generator, divides clk_sys by the turbo mask and gates with cpu_en
`timescale 1ns/1ps

module cpu_clock_gen #(
	parameter int CNT_W = 6
) (
	input logic clk_sys,
	input logic reset,
	input zx_host_core_pkg::speed_t speed,
	input logic cpu_en,
	output logic tick_n,
	output logic ce_cpu_p,
	output logic ce_cpu_n
);

	// Free-running divider and its view through the speed mask
	logic [CNT_W-1:0] counter;
	logic [CNT_W-1:0] mask;
	logic [CNT_W-1:0] phase;
	logic [CNT_W-1:0] half_mark;
	logic tick_p;

	assign mask = CNT_W'(speed);
	assign phase = counter & mask;

	// Highest mask bit only, i.e. half a CPU period after phase zero
	assign half_mark = mask ^ (mask >> 1);

	// ========================================
	// Divider and raw ticks
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			counter <= '0;
			tick_p <= 1'b0;
			tick_n <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			tick_p <= (phase == '0);
			// At divide by 2 this lands on the odd cycle
			tick_n <= (phase == half_mark);
		end
	end

	// ========================================
	// Gated enables to the CPU
	// ========================================

	assign ce_cpu_p = tick_p & cpu_en;
	assign ce_cpu_n = tick_n & cpu_en;

endmodule

// ==== speed_ctrl.sv ====
// Speed sequencer, applies turbo requests and holds the CPU on settle, pause and SDRAM wait
`timescale 1ns/1ps

module speed_ctrl (
	input logic clk_sys,
	input logic reset,
	input logic tick_n,
	input zx_host_core_pkg::speed_t speed_req,
	input logic pause,
	input logic ram_ready,
	output zx_host_core_pkg::speed_t speed,
	output logic cpu_en
);

	typedef enum logic [1:0] {
		ST_RUN,
		ST_SETTLE,
		ST_RAM_WAIT,
		ST_PAUSED
	} state_t;

	state_t state;
	logic [1:0] settle_cnt;
	logic speed_change;
	logic fast_speed;
	logic can_run;

	assign speed_change = (speed_req != speed);

	// Only the two fastest dividers outrun the SDRAM
	assign fast_speed = (speed[4:2] == 3'b000);
	assign can_run = ram_ready & ~pause;

	// CPU runs only in RUN
	assign cpu_en = (state == ST_RUN);

	// ========================================
	// Sequencer, steps on the negative tick
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= ST_RUN;
			speed <= zx_host_core_pkg::SPEED_3M5;
			settle_cnt <= 2'd0;
		end else if (tick_n) begin
			if (speed_change) begin
				// New request restarts the settle time from any state
				state <= ST_SETTLE;
				speed <= speed_req;
				settle_cnt <= 2'd0;
			end else begin
				case (state)
					ST_RUN: begin
						if (fast_speed & ~ram_ready) begin
							state <= ST_RAM_WAIT;
						end else if (pause) begin
							state <= ST_PAUSED;
						end
					end
					ST_SETTLE: begin
						if (settle_cnt != 2'd2) begin
							settle_cnt <= settle_cnt + 2'd1;
						end else if (can_run) begin
							state <= ST_RUN;
						end
					end
					ST_RAM_WAIT: begin
						if (can_run) begin
							state <= ST_RUN;
						end else if (ram_ready) begin
							state <= ST_PAUSED;
						end
					end
					ST_PAUSED: begin
						if (can_run) begin
							state <= ST_RUN;
						end
					end
					default: begin
						state <= ST_RUN;
					end
				endcase
			end
		end
	end

endmodule

// ==== port_regs.sv ====
// Paging ports 7FFD and DFFD and the ULA port FE, written on the CPU I/O write edge
`timescale 1ns/1ps

module port_regs (
	input logic clk_sys,
	input logic reset,
	input zx_host_core_pkg::cpu_bus_t bus,
	input zx_host_core_pkg::mem_mode_t mode,
	output zx_host_core_pkg::page_state_t pages,
	output zx_host_core_pkg::ula_port_t ula
);

	// I/O write strobe and its previous value
	logic io_wr;
	logic io_wr_q;
	logic io_wr_edge;

	// Memory model flags, taken while reset is high
	logic zx48;
	logic p512;
	logic pf1024;

	// 7FFD bits 5:0 and the extended page above them
	logic [5:0] page_7ffd;
	logic [2:0] page_ext;

	logic page_sel;
	logic page_lock;
	logic dffd_sel;
	logic ula_sel;

	assign io_wr = bus.iorq & bus.wr & ~bus.m1;
	assign io_wr_edge = io_wr & ~io_wr_q;

	// Partial decode, A15 and A1 low
	assign page_sel = ~bus.addr[15] & ~bus.addr[1];
	assign page_lock = zx48 | page_7ffd[5];
	assign dffd_sel = pf1024 & (bus.addr == zx_host_core_pkg::PORT_DFFD);
	assign ula_sel = ~bus.addr[0];

	// ========================================
	// Port writes
	// ========================================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			zx48 <= (mode == zx_host_core_pkg::MODE_48K);
			p512 <= (mode == zx_host_core_pkg::MODE_P512);
			pf1024 <= (mode == zx_host_core_pkg::MODE_P1024);
			page_7ffd <= 6'd0;
			page_ext <= 3'd0;
			ula <= '0;
		end else begin
			io_wr_q <= io_wr;
			if (io_wr_edge) begin
				if (page_sel & ~page_lock) begin
					page_7ffd <= bus.dout[5:0];
					// Pentagon 512K keeps its two extra bits in D7..D6
					if (p512) begin
						page_ext[1:0] <= bus.dout[7:6];
					end
				end
				if (dffd_sel) begin
					page_ext <= bus.dout[2:0];
				end
				if (ula_sel) begin
					ula.border <= bus.dout[2:0];
					ula.mic <= bus.dout[3];
					ula.ear <= bus.dout[4];
				end
			end
		end
	end

	// ========================================
	// Paging outputs
	// ========================================

	// ROM 3 is the 48K BASIC image
	assign pages.rom_page = (zx48 | page_7ffd[4]) ? 2'd3 : 2'd2;
	assign pages.ram_page = {page_ext, page_7ffd[2:0]};
	assign pages.scr_page = page_7ffd[3];

endmodule

// ==== mem_map.sv ====
// CPU-to-SDRAM address map, turns each CPU memory cycle into an SDRAM request
`timescale 1ns/1ps

module mem_map #(
	parameter int RAM_AW = zx_host_core_pkg::RAM_AW
) (
	input zx_host_core_pkg::cpu_bus_t bus,
	input zx_host_core_pkg::page_state_t pages,
	output zx_host_core_pkg::ram_req_t ram
);

	// ROM base, page and offset fill bits 20:0
	localparam int MAP_W = 21;

	logic [13:0] offset;
	logic [1:0] quarter;
	logic [MAP_W-1:0] map_addr;
	logic [RAM_AW-1:0] ram_addr;
	logic rom_area;

	assign offset = bus.addr[13:0];
	assign quarter = bus.addr[15:14];
	assign rom_area = (quarter == 2'b00);

	// ========================================
	// Quarter decode
	// ========================================

	always_comb begin
		case (quarter)
			2'b00: begin
				map_addr = {zx_host_core_pkg::ROM_BASE, pages.rom_page, offset};
			end
			2'b01: begin
				map_addr = MAP_W'({zx_host_core_pkg::BANK_SCREEN, offset});
			end
			2'b10: begin
				map_addr = MAP_W'({zx_host_core_pkg::BANK_MID, offset});
			end
			default: begin
				// Banked RAM at C000
				map_addr = MAP_W'({pages.ram_page, offset});
			end
		endcase
	end

	assign ram_addr = RAM_AW'(map_addr);

	// ========================================
	// Request
	// ========================================

	assign ram.addr = ram_addr;
	assign ram.din = bus.dout;
	assign ram.rd = bus.mreq & bus.rd;
	// ROM is write protected
	assign ram.we = bus.mreq & bus.wr & ~rom_area;

endmodule

// ==== zx_host_core.sv ====
// Top of the Spectrum host core, connects clocking, speed control, ports and memory map
`timescale 1ns/1ps

module zx_host_core #(
	parameter int RAM_AW = zx_host_core_pkg::RAM_AW,
	parameter int CNT_W = 6
) (
	input logic clk_sys,
	input logic reset,
	input zx_host_core_pkg::cpu_bus_t bus,
	input zx_host_core_pkg::speed_t speed_req,
	input logic pause,
	input zx_host_core_pkg::mem_mode_t mode,
	input logic ram_ready,
	output zx_host_core_pkg::ram_req_t ram,
	output zx_host_core_pkg::ula_port_t ula,
	output logic ce_cpu_p,
	output logic ce_cpu_n
);

	logic tick_n;
	logic cpu_en;
	zx_host_core_pkg::speed_t speed;
	zx_host_core_pkg::page_state_t pages;

	// ========================================
	// CPU clocking
	// ========================================

	cpu_clock_gen #(
		.CNT_W(CNT_W)
	) i_cpu_clock_gen (
		.clk_sys(clk_sys),
		.reset(reset),
		.speed(speed),
		.cpu_en(cpu_en),
		.tick_n(tick_n),
		.ce_cpu_p(ce_cpu_p),
		.ce_cpu_n(ce_cpu_n)
	);

	speed_ctrl i_speed_ctrl (
		.clk_sys(clk_sys),
		.reset(reset),
		.tick_n(tick_n),
		.speed_req(speed_req),
		.pause(pause),
		.ram_ready(ram_ready),
		.speed(speed),
		.cpu_en(cpu_en)
	);

	// ========================================
	// Ports and memory
	// ========================================

	port_regs i_port_regs (
		.clk_sys(clk_sys),
		.reset(reset),
		.bus(bus),
		.mode(mode),
		.pages(pages),
		.ula(ula)
	);

	mem_map #(
		.RAM_AW(RAM_AW)
	) i_mem_map (
		.bus(bus),
		.pages(pages),
		.ram(ram)
	);

endmodule

// ==== zx_host_core_assert.sv ====
// Concurrent checks on the host core outputs, bound to every zx_host_core instance
`timescale 1ns/1ps

module zx_host_core_assert (
	input logic clk_sys,
	input logic reset,
	input zx_host_core_pkg::cpu_bus_t bus,
	input zx_host_core_pkg::ram_req_t ram,
	input logic ce_cpu_p,
	input logic ce_cpu_n
);

	// The two CPU clock phases never share a cycle
	ce_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(ce_cpu_p && ce_cpu_n))
		else $error("ce_cpu_p and ce_cpu_n high in the same cycle");

	// One cycle into reset the enables are cleared
	ce_low_in_reset: assert property (@(posedge clk_sys)
		(reset && $past(reset)) |-> (!ce_cpu_p && !ce_cpu_n))
		else $error("CPU clock enable high during reset");

	// ROM quarter is write protected
	rom_no_write: assert property (@(posedge clk_sys) disable iff (reset)
		ram.we |-> (bus.addr[15:14] != 2'b00))
		else $error("SDRAM write enable raised for an address below 4000");

endmodule

bind zx_host_core zx_host_core_assert i_assert (
	.clk_sys(clk_sys),
	.reset(reset),
	.bus(bus),
	.ram(ram),
	.ce_cpu_p(ce_cpu_p),
	.ce_cpu_n(ce_cpu_n)
);

// ==== tb_zx_host_core.sv ====
// Testbench for the host core, drives CPU bus cycles and checks memory map, ports and CPU enables
`timescale 1ns/1ps

module tb_zx_host_core;

	localparam logic [31:0] LFSR_SEED = 32'h2478;
	localparam int WAIT_LIMIT = 400;
	localparam int AW = zx_host_core_pkg::RAM_AW;

	logic clk_sys = 1'b0;
	logic reset;
	zx_host_core_pkg::cpu_bus_t bus;
	zx_host_core_pkg::speed_t speed_req;
	logic pause;
	zx_host_core_pkg::mem_mode_t mode;
	logic ram_ready;
	zx_host_core_pkg::ram_req_t ram;
	zx_host_core_pkg::ula_port_t ula;
	logic ce_cpu_p;
	logic ce_cpu_n;

	// Port state as the testbench expects it after its own writes
	logic [7:0] model_7ffd;
	logic [2:0] model_ext;
	zx_host_core_pkg::ula_port_t model_ula;
	logic [31:0] lfsr = LFSR_SEED;
	int error_count = 0;
	int check_count = 0;
	int errors_before;
	logic [31:0] r;

	zx_host_core #(.RAM_AW(AW), .CNT_W(6)) i_dut (.*);

	always #5 clk_sys = ~clk_sys;

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
	endfunction

	task automatic random_bits(input int nbits, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < nbits; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// Reference map: quarter select, then ROM page, fixed bank or banked page
	function automatic logic [AW-1:0] expected_ram_addr(input logic [15:0] addr,
			input logic [7:0] reg_7ffd, input logic [2:0] ext, input logic is_48k);
		logic [1:0] rom_page;
		rom_page = (is_48k || reg_7ffd[4]) ? 2'd3 : 2'd2;
		case (addr[15:14])
			2'b00: return AW'({zx_host_core_pkg::ROM_BASE, rom_page, addr[13:0]});
			2'b01: return AW'({zx_host_core_pkg::BANK_SCREEN, addr[13:0]});
			2'b10: return AW'({zx_host_core_pkg::BANK_MID, addr[13:0]});
			default: return AW'({ext, reg_7ffd[2:0], addr[13:0]});
		endcase
	endfunction

	function automatic int expected_period(input zx_host_core_pkg::speed_t speed);
		int ones;
		ones = 0;
		for (int i = 0; i < 5; i++) begin
			ones += speed[i];
		end
		return 1 << ones;
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count++;
		if (got !== expected) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, expected);
		end
	endtask

	// Every memory cycle is compared with the reference map
	always @(posedge clk_sys) begin
		if (!reset && bus.mreq) begin
			check_value("ram.addr", ram.addr, expected_ram_addr(bus.addr, model_7ffd,
				model_ext, mode == zx_host_core_pkg::MODE_48K));
			check_value("ram.rd", ram.rd, bus.rd);
			check_value("ram.we", ram.we, bus.wr && (bus.addr[15:14] != 2'b00));
			check_value("ram.din", ram.din, bus.dout);
		end
	end

	// ========================================
	// Bus and reset tasks, all start and end on a falling edge
	// ========================================

	task automatic apply_reset(input zx_host_core_pkg::mem_mode_t new_mode);
		reset = 1'b1;
		mode = new_mode;
		bus = '0;
		speed_req = zx_host_core_pkg::SPEED_3M5;
		pause = 1'b0;
		repeat (16) @(negedge clk_sys);
		reset = 1'b0;
		model_7ffd = '0;
		model_ext = '0;
		model_ula = '0;
	endtask

	task automatic mem_cycle(input logic [15:0] addr, input logic [7:0] data, input logic write);
		bus = '0;
		bus.addr = addr;
		bus.dout = data;
		bus.mreq = 1'b1;
		bus.rd = ~write;
		bus.wr = write;
		@(negedge clk_sys);
		bus = '0;
	endtask

	task automatic random_accesses(input int count, input logic write);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			random_bits(22, rnd);
			// Loop index picks the quarter so all four are covered
			mem_cycle({i[1:0], rnd[13:0]}, rnd[21:14], write);
		end
	endtask

	task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
		bus = '0;
		bus.addr = addr;
		bus.dout = data;
		bus.iorq = 1'b1;
		bus.wr = 1'b1;
		@(negedge clk_sys);
		bus = '0;
		@(negedge clk_sys);
		if (!addr[15] && !addr[1] && mode != zx_host_core_pkg::MODE_48K && !model_7ffd[5]) begin
			model_7ffd = data;
			if (mode == zx_host_core_pkg::MODE_P512) begin
				model_ext[1:0] = data[7:6];
			end
		end
		if (mode == zx_host_core_pkg::MODE_P1024 && addr == zx_host_core_pkg::PORT_DFFD) begin
			model_ext = data[2:0];
		end
		if (!addr[0]) begin
			model_ula.border = data[2:0];
			model_ula.mic = data[3];
			model_ula.ear = data[4];
		end
	endtask

	// ========================================
	// CPU enable tasks
	// ========================================

	// Returns on the falling edge where the chosen enable is high
	task automatic wait_enable(input logic on_p, input string what);
		int cycles;
		cycles = 0;
		do begin
			@(negedge clk_sys);
			cycles++;
			if (cycles > WAIT_LIMIT) begin
				$display("Timeout while waiting for %s", what);
				error_count++;
				return;
			end
		end while (!(on_p ? ce_cpu_p : ce_cpu_n));
	endtask

	// Period of ce_cpu_p, with ce_cpu_n half a period after each pulse
	task automatic check_spacing(input int pulses, input int expected);
		int cycles;
		int n_cycle;
		for (int i = 0; i < pulses; i++) begin
			cycles = 0;
			n_cycle = 0;
			do begin
				@(negedge clk_sys);
				cycles++;
				if (ce_cpu_n) begin
					n_cycle = cycles;
				end
				if (cycles > WAIT_LIMIT) begin
					$display("Timeout while waiting for the next ce_cpu_p");
					error_count++;
					return;
				end
			end while (!ce_cpu_p);
			check_value("ce_cpu_p spacing", cycles, expected);
			check_value("ce_cpu_n offset", n_cycle, expected / 2);
		end
	endtask

	task automatic test_speeds();
		zx_host_core_pkg::speed_t speeds [5];
		int pulses;
		speeds = '{zx_host_core_pkg::SPEED_3M5, zx_host_core_pkg::SPEED_7M,
			zx_host_core_pkg::SPEED_14M, zx_host_core_pkg::SPEED_28M, zx_host_core_pkg::SPEED_56M};
		foreach (speeds[s]) begin
			wait_enable(1'b1, "ce_cpu_p before speed change");
			speed_req = speeds[s];
			wait_enable(1'b0, "ce_cpu_n that takes the speed change");
			wait_enable(1'b1, "first ce_cpu_p at the new speed");
			check_spacing(4, expected_period(speeds[s]));
			pause = 1'b1;
			wait_enable(1'b0, "ce_cpu_n that takes the pause");
			pulses = 0;
			repeat (128) begin
				@(negedge clk_sys);
				pulses += ce_cpu_p + ce_cpu_n;
			end
			check_value("ce pulses while paused", pulses, 0);
			pause = 1'b0;
			wait_enable(1'b1, "ce_cpu_p after pause release");
			check_spacing(2, expected_period(speeds[s]));
		end
	endtask

	// SDRAM busy at the fastest speed holds the CPU until ram_ready returns
	task automatic test_ram_wait();
		int pulses;
		speed_req = zx_host_core_pkg::SPEED_56M;
		wait_enable(1'b1, "ce_cpu_p before SDRAM busy");
		ram_ready = 1'b0;
		wait_enable(1'b0, "ce_cpu_n that sees SDRAM busy");
		pulses = 0;
		repeat (32) begin
			@(negedge clk_sys);
			pulses += ce_cpu_p + ce_cpu_n;
		end
		check_value("ce pulses while SDRAM busy", pulses, 0);
		ram_ready = 1'b1;
		wait_enable(1'b1, "ce_cpu_p after SDRAM ready");
		check_spacing(2, expected_period(zx_host_core_pkg::SPEED_56M));
	endtask

	task automatic report_test(input string name);
		if (error_count == errors_before) begin
			$display("Test %s passed", name);
		end else begin
			$display("Test %s failed with %0d errors", name, error_count - errors_before);
		end
		errors_before = error_count;
	endtask

	// ========================================
	// Test sequence
	// ========================================

	initial begin
		reset = 1'b1;
		bus = '0;
		speed_req = zx_host_core_pkg::SPEED_3M5;
		pause = 1'b0;
		mode = zx_host_core_pkg::MODE_128K;
		ram_ready = 1'b1;
		errors_before = 0;
		apply_reset(zx_host_core_pkg::MODE_128K);
		random_accesses(16, 1'b0);
		report_test("reset mapping");

		for (int i = 0; i < 12; i++) begin
			random_bits(8, r);
			// Lock bit set only on the ninth write
			io_write(16'h7FFD, (i == 8) ? (r[7:0] | 8'h20) : (r[7:0] & 8'hDF));
			random_accesses(4, 1'b0);
		end
		apply_reset(zx_host_core_pkg::MODE_48K);
		for (int i = 0; i < 4; i++) begin
			random_bits(8, r);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			random_accesses(4, 1'b0);
		end
		report_test("7FFD paging");

		apply_reset(zx_host_core_pkg::MODE_P512);
		for (int i = 0; i < 4; i++) begin
			random_bits(8, r);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			random_accesses(4, 1'b0);
		end
		apply_reset(zx_host_core_pkg::MODE_P1024);
		for (int i = 0; i < 4; i++) begin
			random_bits(16, r);
			io_write(16'h7FFD, r[7:0] & 8'hDF);
			io_write(zx_host_core_pkg::PORT_DFFD, r[15:8]);
			random_accesses(4, 1'b0);
		end
		report_test("extended pages");

		random_accesses(16, 1'b1);
		report_test("write protection");

		for (int i = 0; i < 12; i++) begin
			random_bits(24, r);
			// Even ports first, then odd ports that must leave ula alone
			io_write({r[15:1], (i >= 8) ? 1'b1 : 1'b0}, r[23:16]);
			check_value("ula", ula, model_ula);
		end
		report_test("ULA port");

		test_speeds();
		report_test("CPU clock enables");

		test_ram_wait();
		report_test("SDRAM wait");

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

// ==== zx_host_core.f ====
zx_host_core_pkg.sv
cpu_clock_gen.sv
speed_ctrl.sv
port_regs.sv
mem_map.sv
zx_host_core.sv
zx_host_core_assert.sv
tb_zx_host_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_zx_host_core \
	-f zx_host_core.f -o sim_zx_host_core

output="$(./obj_dir/sim_zx_host_core 2>&1)" || true
printf '%s\n' "$output"

if grep -qF -- "** PASS **" <<< "$output"; then
	exit 0
fi
exit 1
